// ==== fmaFmtPkg.sv ====
// binary16 format package with the field widths and datapath types of the FMA unit
package fmaFmtPkg;

    //////////////////////////////
    // stored fields
    //////////////////////////////
    parameter int ExpWidth  = 5;
    parameter int FracWidth = 10;
    parameter int Bias      = 15;

    // derived datapath widths
    parameter int SigWidth    = FracWidth + 1;
    parameter int ProdWidth   = 2*FracWidth + 2;
    parameter int WideWidth   = 3*FracWidth + 6;
    parameter int SumExpWidth = ExpWidth + 2;
    parameter int WordWidth   = 1 + ExpWidth + FracWidth;
    // wide field bit that carries the weight of the sum exponent
    parameter int PointPos    = 2*FracWidth + 2;

    typedef logic [ExpWidth-1:0]    expT;
    typedef logic [FracWidth-1:0]   fracT;
    // significand with the hidden one on top
    typedef logic [SigWidth-1:0]    sigT;
    // product in U2.2F form
    typedef logic [ProdWidth-1:0]   prodT;
    // aligned addend and sum, one spare carry bit on top
    typedef logic [WideWidth-1:0]   wideT;
    // biased exponent kept in two's complement so it may dip below zero
    typedef logic [SumExpWidth-1:0] sumExpT;
    typedef logic [WordWidth-1:0]   fpT;

endpackage

// ==== fmaFlowPkg.sv ====
// credit flow control package for the output side of the FMA unit
package fmaFlowPkg;

    // width of the credit counter
    parameter int CreditWidth = 4;

    // credits in hand, zero up to the configured depth
    typedef logic [CreditWidth-1:0] creditT;

    // deepest sink the counter can track
    parameter int MaxCreditsLimit = (1 << CreditWidth) - 1;

endpackage

// ==== fmaStageIf.sv ====
// pipeline register bundle from the multiply/align stage to the adder and normalizer
`timescale 1ns/100ps

interface fmaStageIf
    import fmaFmtPkg::*;
();

    // stage holds a live item
    logic   valid;
    // aligned addend, not yet inverted
    wideT   am;
    // significand product
    prodT   pm;
    // product sign
    logic   ps;
    // signs differ so the addend gets subtracted
    logic   invA;
    // addend dominates, product only counts as a sticky
    logic   killProd;
    // nonzero bits lost below the field
    logic   zmSticky;
    // addend exponent
    expT    ze;
    // product exponent
    sumExpT pe;

    modport producer (output valid, am, pm, ps, invA, killProd, zmSticky, ze, pe);
    modport consumer (input valid, am, pm, ps, invA, killProd, zmSticky, ze, pe);

endinterface

// ==== fmaMulAlign.sv ====
// multiply/align stage of the FMA, forms the significand product and lines up the addend
`timescale 1ns/100ps

module fmaMulAlign
    import fmaFmtPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        launch,
    input  fpT          x,
    input  fpT          y,
    input  fpT          z,
    fmaStageIf.producer stage
);

    // addend preshift puts its top bit just under the spare carry bit
    localparam int AlignOffset = WideWidth - 2 - PointPos;
    // bits below the field that catch what the shift drops
    localparam int CatchWidth  = SigWidth;
    localparam int ShiftWidth  = SumExpWidth + 1;

    expT                               xExp;
    expT                               yExp;
    expT                               zExp;
    sigT                               xSig;
    sigT                               ySig;
    sigT                               zSig;
    logic                              prodSign;
    prodT                              prod;
    sumExpT                            prodExp;
    logic [ShiftWidth-1:0]             alignCnt;
    logic                              killNext;
    logic                              stickyNext;
    logic [WideWidth+CatchWidth-1:0]   zPre;
    logic [WideWidth+CatchWidth-1:0]   zShift;

    //////////////////////////////
    // unpack and multiply
    //////////////////////////////
    assign xExp = x[FracWidth +: ExpWidth];
    assign yExp = y[FracWidth +: ExpWidth];
    assign zExp = z[FracWidth +: ExpWidth];
    // hidden one only for a nonzero exponent
    assign xSig = {|xExp, x[FracWidth-1:0]};
    assign ySig = {|yExp, y[FracWidth-1:0]};
    assign zSig = {|zExp, z[FracWidth-1:0]};

    assign prodSign = x[WordWidth-1] ^ y[WordWidth-1];
    assign prod     = xSig * ySig;
    // biased product exponent, weight of prod bit 2*FracWidth
    assign prodExp  = sumExpT'(xExp) + sumExpT'(yExp) - sumExpT'(Bias);

    //////////////////////////////
    // addend alignment
    //////////////////////////////
    // right shift of the addend, product exponent minus addend exponent plus offset
    assign alignCnt = {prodExp[SumExpWidth-1], prodExp}
                    - {{(ShiftWidth-ExpWidth){1'b0}}, zExp}
                    + ShiftWidth'(AlignOffset);

    // negative count means the addend dominates, a zero product is dropped too
    assign killNext = zSig[FracWidth]
                    & (alignCnt[ShiftWidth-1] | ~(xSig[FracWidth] & ySig[FracWidth]));

    assign zPre = {1'b0, zSig, {(WideWidth+CatchWidth-1-SigWidth){1'b0}}};

    always_comb begin
        zShift     = '0;
        stickyNext = 1'b0;
        if (killNext) begin
            // addend sits at the product point so ze keeps its meaning
            zShift     = zPre >> AlignOffset;
            stickyNext = |prod;
        end else if (alignCnt < ShiftWidth'(WideWidth)) begin
            zShift     = zPre >> alignCnt;
            stickyNext = |zShift[CatchWidth-1:0];
        end else begin
            // shifted clean out of the field
            stickyNext = |zSig;
        end
    end

    //////////////////////////////
    // stage register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= launch;
        end
    end

    // payload only loads on an accepted word
    always_ff @(posedge clk) begin
        if (launch) begin
            stage.am       <= zShift[WideWidth+CatchWidth-1 -: WideWidth];
            stage.pm       <= prod;
            stage.ps       <= prodSign;
            stage.invA     <= prodSign ^ z[WordWidth-1];
            stage.killProd <= killNext;
            stage.zmSticky <= stickyNext;
            stage.ze       <= zExp;
            stage.pe       <= prodExp;
        end
    end

endmodule

// ==== fmaAdd.sv ====
// significand adder of the FMA, yields the positive sum with its sign and exponent
`timescale 1ns/100ps

module fmaAdd
    import fmaFmtPkg::*;
(
    fmaStageIf.consumer stage,
    output wideT        sm,
    output logic        ss,
    output sumExpT      se
);

    wideT amInv;
    prodT pmKilled;
    wideT preSum;
    wideT negPreSum;
    logic negSum;

    //////////////////////////////
    // operand prep
    //////////////////////////////
    // ones complement for subtraction, the missing one comes in as a carry
    assign amInv    = stage.invA ? ~stage.am : stage.am;
    // product too small to matter
    assign pmKilled = stage.killProd ? '0 : stage.pm;

    //////////////////////////////
    // parallel sums
    //////////////////////////////
    // p - a in the extended bit, carry out flags a negative result
    // addend sticky drops the +1 so the sum floors
    // a killed product under subtraction always leaves this sum negative
    assign {negSum, preSum} = {{(WideWidth-ProdWidth-1){1'b0}}, pmKilled, 2'b00}
                            + {stage.invA, amInv}
                            + {{WideWidth{1'b0}}, stage.invA & ~stage.zmSticky};

    // a - p for the negative case
    // a killed nonzero product takes one off the addend
    assign negPreSum = stage.am
                     + {{(WideWidth-ProdWidth-2){1'b1}}, ~pmKilled, 2'b11}
                     + {{(WideWidth-1){1'b0}}, ~(stage.zmSticky & stage.killProd)};

    // keep whichever sum is positive
    assign sm = negSum ? negPreSum : preSum;
    // flips the product sign when the addend won
    assign ss = negSum ^ stage.ps;
    // killed product leaves the addend exponent at the point
    assign se = stage.killProd ? sumExpT'(stage.ze) : stage.pe;

endmodule

// ==== fmaNorm.sv ====
// normalize and pack stage of the FMA, truncates the sum into a binary16 result
`timescale 1ns/100ps

module fmaNorm
    import fmaFmtPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    fmaStageIf.consumer stage,
    input  wideT        sm,
    input  logic        ss,
    input  sumExpT      se,
    output logic        outValid,
    output fpT          result
);

    // se weighs bit PointPos, leading one lands at the top bit
    localparam int ExpAdjust  = WideWidth - 1 - PointPos;
    localparam int CountWidth = $clog2(WideWidth + 1);

    logic [CountWidth-1:0] lzc;
    logic                  found;
    wideT                  smNorm;
    sumExpT                normExp;
    fpT                    resNext;

    //////////////////////////////
    // leading zero count
    //////////////////////////////
    always_comb begin
        lzc   = CountWidth'(WideWidth);
        found = 1'b0;
        // first set bit from the top wins
        for (int i = WideWidth - 1; i >= 0; i--) begin
            if (!found && sm[i]) begin
                lzc   = CountWidth'(WideWidth - 1 - i);
                found = 1'b1;
            end
        end
    end

    // leading one to the top bit
    assign smNorm  = sm << lzc;
    // move the exponent by how far the leading one sits from the point
    assign normExp = se + sumExpT'(ExpAdjust) - sumExpT'(lzc);

    always_comb begin
        if (found) begin
            // fraction right under the leading one, the rest truncated
            resNext = {ss, normExp[ExpWidth-1:0], smNorm[WideWidth-2 -: FracWidth]};
        end else begin
            // exact cancellation is +0
            resNext = '0;
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= stage.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage.valid) begin
            result <= resNext;
        end
    end

endmodule

// ==== fmaCreditCnt.sv ====
// credit counter, issues words only while the downstream sink has room
`timescale 1ns/100ps

module fmaCreditCnt
    import fmaFlowPkg::*;
#(
    parameter creditT maxCredits = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  logic creditReturn,
    output logic inReady,
    output logic launch
);

    creditT count;

    // any credit left lets a word in
    assign inReady = (count != '0);
    // the one place a word gets accepted
    assign launch  = inValid & inReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= maxCredits;
        end else begin
            case ({launch, creditReturn})
                // take one on issue
                2'b10: count <= count - 1'b1;
                // a returned credit
                2'b01: count <= count + 1'b1;
                // both or neither leaves it alone
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== fmaUnit.sv ====
// binary16 fused multiply-add top level, two pipeline stages with output credits
`timescale 1ns/100ps

module fmaUnit
    import fmaFmtPkg::*, fmaFlowPkg::*;
#(
    parameter int maxCredits = 4
) (
    input  logic clk,
    input  logic rstN,
    // source side
    input  logic inValid,
    input  fpT   x,
    input  fpT   y,
    input  fpT   z,
    output logic inReady,
    // sink side
    output logic outValid,
    output fpT   result,
    input  logic creditReturn
);

    // depth for the counter, held to what its width can count
    localparam creditT CreditDepth =
        creditT'((maxCredits > MaxCreditsLimit) ? MaxCreditsLimit : maxCredits);

    logic   launch;
    wideT   sm;
    logic   ss;
    sumExpT se;

    // multiply/align results on their way to the adder and normalizer
    fmaStageIf stageBus ();

    //////////////////////////////
    // flow control
    //////////////////////////////
    fmaCreditCnt #(
        .maxCredits(CreditDepth)
    ) creditCnt (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .creditReturn(creditReturn),
        .inReady     (inReady),
        .launch      (launch)
    );

    //////////////////////////////
    // datapath
    //////////////////////////////
    // first stage registers on the accepting edge
    fmaMulAlign mulAlign (
        .clk   (clk),
        .rstN  (rstN),
        .launch(launch),
        .x     (x),
        .y     (y),
        .z     (z),
        .stage (stageBus.producer)
    );

    // adder sits between the stage register and the output register
    fmaAdd add (
        .stage(stageBus.consumer),
        .sm   (sm),
        .ss   (ss),
        .se   (se)
    );

    fmaNorm norm (
        .clk     (clk),
        .rstN    (rstN),
        .stage   (stageBus.consumer),
        .sm      (sm),
        .ss      (ss),
        .se      (se),
        .outValid(outValid),
        .result  (result)
    );

endmodule

// ==== tbFmaVectors.svh ====
// stimulus table for the FMA testbench, operand triples with truncated results and credit delays
`ifndef tbFmaVectorsSvh
`define tbFmaVectorsSvh

// columns: x, y, z, expected x*y+z rounded toward zero, credit-return delay in cycles
localparam int NumRows = 18;

logic [71:0] vecTable [NumRows];

task automatic loadVectors();
    // like-sign sums, 2*3+1, 1.5*1.5+1, 2*2+4, -2*3-1, 0.5*0.5+0.5
    vecTable[0]  = {16'h4000, 16'h4200, 16'h3C00, 16'h4700, 8'd1};
    vecTable[1]  = {16'h3E00, 16'h3E00, 16'h3C00, 16'h4280, 8'd1};
    vecTable[2]  = {16'h4000, 16'h4000, 16'h4400, 16'h4800, 8'd2};
    vecTable[3]  = {16'hC000, 16'h4200, 16'hBC00, 16'hC700, 8'd1};
    vecTable[4]  = {16'h3800, 16'h3800, 16'h3800, 16'h3A00, 8'd3};
    // inexact product, low bits truncated
    vecTable[5]  = {16'h3C01, 16'h3C01, 16'h3C00, 16'h4001, 8'd1};
    //////////////////////////////
    // effective subtraction, long delays drain the credits
    //////////////////////////////
    // 6-10, 1-3, 3-8 give a negative sum
    vecTable[6]  = {16'h4000, 16'h4200, 16'hC900, 16'hC400, 8'd12};
    vecTable[7]  = {16'h3C00, 16'h3C00, 16'hC200, 16'hC000, 8'd12};
    vecTable[8]  = {16'h3E00, 16'h4000, 16'hC800, 16'hC500, 8'd12};
    // 12-5 stays positive
    vecTable[9]  = {16'h4200, 16'h4400, 16'hC500, 16'h4700, 8'd10};
    // 1.0009765625-4, magnitude truncated down to 2.998046875
    vecTable[10] = {16'h3C00, 16'h3C01, 16'hC400, 16'hC1FF, 8'd1};
    //////////////////////////////
    // killed product and sticky addend
    //////////////////////////////
    // 1024 +- 1/16, product far below the addend
    vecTable[11] = {16'h3400, 16'h3400, 16'h6400, 16'h6400, 8'd2};
    vecTable[12] = {16'h3400, 16'hB400, 16'h6400, 16'h63FF, 8'd1};
    vecTable[13] = {16'h3400, 16'h3400, 16'hE400, 16'hE3FF, 8'd1};
    // 1024 +- tiny addend, the second one falls out of the field
    vecTable[14] = {16'h5000, 16'h5000, 16'h1400, 16'h6400, 8'd1};
    vecTable[15] = {16'h5000, 16'h5000, 16'h8400, 16'h63FF, 8'd3};
    // exact cancellation gives +0
    vecTable[16] = {16'h4000, 16'h4200, 16'hC600, 16'h0000, 8'd1};
    vecTable[17] = {16'h3E00, 16'h3E00, 16'hC080, 16'h0000, 8'd1};
endtask

`endif

// ==== tbFmaUnit.sv ====
// testbench for the binary16 FMA unit, table rows through the pipe into a credit-returning sink
`timescale 1ns/100ps

module tbFmaUnit;

    localparam int MaxCredits  = 4;
    localparam int ResetCycles = 8;
    // sample edge of a result, counted from its accepting edge
    localparam int Latency     = 2;

    logic        clk = 1'b0;
    logic        rstN;
    logic        inValid;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] z;
    logic        inReady;
    logic        outValid;
    logic [15:0] result;
    logic        creditReturn;

    `include "tbFmaVectors.svh"

    int cycle      = 0;
    int sendIdx    = 0;
    // credits held by accepted items not yet returned
    int owed       = 0;
    int doneCount  = 0;
    int passCount  = 0;
    int errorCount = 0;
    int maxDelay   = 0;
    int cycleLimit = 0;
    // in-flight rows with their accepting edge, then due edges of credit returns
    int pendRow[$];
    int pendEdge[$];
    int retDue[$];

    fmaUnit #(
        .maxCredits(MaxCredits)
    ) dut (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .x           (x),
        .y           (y),
        .z           (z),
        .inReady     (inReady),
        .outValid    (outValid),
        .result      (result),
        .creditReturn(creditReturn)
    );

    always #20 clk = ~clk;

    // compare one finished result against the oldest row in flight
    task automatic checkResult();
        int          r;
        int          acc;
        logic        rowOk;
        logic [15:0] expRes;
        r      = pendRow.pop_front();
        acc    = pendEdge.pop_front();
        expRes = vecTable[r][23:8];
        rowOk  = 1'b1;
        assert (result === expRes) else begin
            $display("MISMATCH result row %0d: got %h expected %h", r, result, expRes);
            rowOk = 1'b0;
        end
        assert (cycle == acc + Latency) else begin
            $display("row %0d came %0d cycles after its acceptance instead of %0d",
                     r, cycle - acc, Latency);
            rowOk = 1'b0;
        end
        // sink hands the credit back after the row's own delay
        retDue.push_back(cycle + int'(vecTable[r][7:0]));
        doneCount++;
        if (rowOk) begin
            passCount++;
        end else begin
            errorCount++;
        end
        $display("row %0d: %h * %h + %h -> %h %s", r, vecTable[r][71:56],
                 vecTable[r][55:40], vecTable[r][39:24], result, rowOk ? "ok" : "bad");
    endtask

    //////////////////////////////
    // monitor on the rising edge
    //////////////////////////////
    // pre-edge values, all set at the falling edge or by DUT registers
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rstN) begin
            assert (inReady === (owed < MaxCredits)) else begin
                $display("MISMATCH inReady: got %h expected %h", inReady, owed < MaxCredits);
                errorCount++;
            end
            assert (owed <= MaxCredits) else begin
                $display("%0d results outstanding, more than the %0d credits", owed, MaxCredits);
                errorCount++;
            end
            if (inValid && inReady) begin
                pendRow.push_back(sendIdx);
                pendEdge.push_back(cycle);
                sendIdx++;
                owed++;
            end
            if (creditReturn) begin
                owed--;
            end
            if (outValid === 1'b1) begin
                assert (pendRow.size() > 0) else begin
                    $display("outValid at cycle %0d with nothing in flight", cycle);
                    errorCount++;
                end
                if (pendRow.size() > 0) begin
                    checkResult();
                end
            end
        end
    end

    //////////////////////////////
    // driver and sink on the falling edge
    //////////////////////////////
    always @(negedge clk) begin
        if (cycle < ResetCycles) begin
            rstN         = 1'b0;
            inValid      = 1'b0;
            creditReturn = 1'b0;
        end else begin
            rstN = 1'b1;
            // row stays on the inputs until it is taken
            if (sendIdx < NumRows) begin
                inValid = 1'b1;
                x       = vecTable[sendIdx][71:56];
                y       = vecTable[sendIdx][55:40];
                z       = vecTable[sendIdx][39:24];
            end else begin
                inValid = 1'b0;
            end
            // one return per cycle, oldest first, once its edge is due
            creditReturn = 1'b0;
            if (retDue.size() > 0 && retDue[0] <= cycle + 1) begin
                creditReturn = 1'b1;
                void'(retDue.pop_front());
            end
        end
    end

    initial begin
        rstN         = 1'b0;
        inValid      = 1'b0;
        x            = '0;
        y            = '0;
        z            = '0;
        creditReturn = 1'b0;
        loadVectors();
        for (int i = 0; i < NumRows; i++) begin
            if (int'(vecTable[i][7:0]) > maxDelay) begin
                maxDelay = int'(vecTable[i][7:0]);
            end
        end
        cycleLimit = ResetCycles + NumRows * (Latency + maxDelay) + 20;
        while ((doneCount < NumRows || owed != 0) && cycle < cycleLimit) begin
            @(negedge clk);
        end
        assert (doneCount == NumRows) else begin
            $display("timeout after %0d cycles, only %0d of %0d results arrived",
                     cycle, doneCount, NumRows);
            errorCount++;
        end
        assert (owed == 0) else begin
            $display("timeout after %0d cycles, %0d credits never came back", cycle, owed);
            errorCount++;
        end
        $display("rows %0d of %0d checked, %0d passed, %0d errors",
                 doneCount, NumRows, passCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
fmaFmtPkg.sv
fmaFlowPkg.sv
fmaStageIf.sv
fmaMulAlign.sv
fmaAdd.sv
fmaNorm.sv
fmaCreditCnt.sv
fmaUnit.sv
tbFmaUnit.sv

// ==== Bender.yml ====
package:
  name: fma_unit

sources:
  - fmaFmtPkg.sv
  - fmaFlowPkg.sv
  - fmaStageIf.sv
  - fmaMulAlign.sv
  - fmaAdd.sv
  - fmaNorm.sv
  - fmaCreditCnt.sv
  - fmaUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbFmaUnit.sv
